/* Bender.yml */
package:
  name: exec_pipeline

sources:
  - files:
      - src/core_pkg.sv
      - src/control_unit.sv
      - src/register_file.sv
      - src/execute_unit.sv
      - src/memory_stage.sv
      - src/exec_pipeline.sv
  - target: simulation
    files:
      - testbench/exec_pipeline_checker.sv
      - testbench/exec_pipeline_tb.sv

/* src.f */
src/core_pkg.sv
src/control_unit.sv
src/register_file.sv
src/execute_unit.sv
src/memory_stage.sv
src/exec_pipeline.sv
testbench/exec_pipeline_checker.sv
testbench/exec_pipeline_tb.sv

/* src/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit
   import core_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      we,
   input  logic      stall,
   input  instr_t    instr,
   output logic      issue,
   output logic      ex_valid,
   output logic      regwrite,   // Write-back enable
   output logic      memtoreg,   // Write-back data comes from memory
   output logic      memwrite,
   output logic      memread,
   output logic      byteword,   // 1 for word access, 0 for byte access
   output logic      alusrc,     // Operand B is rt when set, immediate otherwise
   output logic      br_eq,
   output logic      br_ne,
   output alu_op_t   alu_op,
   output reg_addr_t dest,
   output word_t     imm_ext
);

   opcode_t       opcode;
   funct_t        funct;
   logic [15:0]   imm;
   word_t         imm_next;

   assign opcode = instr[31:26];
   assign funct  = instr[5:0];
   assign imm    = instr[15:0];
   assign issue  = we & ~stall;  // One acceptance per rising edge

   always_comb begin
      case (opcode)
         OP_ORI:  imm_next = {16'b0, imm};
         OP_LUI:  imm_next = {imm, 16'b0};
         default: imm_next = {{16{imm[15]}}, imm};  // Loads, stores, LI and ADDI
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_valid <= 1'b0;
         regwrite <= 1'b0;
         memtoreg <= 1'b0;
         memwrite <= 1'b0;
         memread  <= 1'b0;
         byteword <= 1'b0;
         alusrc   <= 1'b0;
         br_eq    <= 1'b0;
         br_ne    <= 1'b0;
         alu_op   <= ALU_ADD;
      end else begin
         ex_valid <= issue;
         // Inactive unless an instruction class below overrides
         regwrite <= 1'b0;
         memtoreg <= 1'b0;
         memwrite <= 1'b0;
         memread  <= 1'b0;
         byteword <= 1'b0;
         alusrc   <= 1'b0;
         br_eq    <= 1'b0;
         br_ne    <= 1'b0;
         alu_op   <= ALU_ADD;
         if (issue) begin
            case (opcode)
               OP_RTYPE: begin
                  regwrite <= 1'b1;
                  alusrc   <= 1'b1;
                  case (funct)
                     FN_SUB:  alu_op <= ALU_SUB;
                     FN_AND:  alu_op <= ALU_AND;
                     FN_OR:   alu_op <= ALU_OR;
                     default: alu_op <= ALU_ADD;
                  endcase
               end
               OP_LDB, OP_LDW: begin
                  regwrite <= 1'b1;
                  memtoreg <= 1'b1;
                  memread  <= 1'b1;
                  byteword <= (opcode == OP_LDW);
               end
               OP_STB, OP_STW: begin
                  memwrite <= 1'b1;
                  byteword <= (opcode == OP_STW);
               end
               OP_LI, OP_LUI: begin
                  regwrite <= 1'b1;
                  alu_op   <= ALU_PASS_B;
               end
               OP_ADDI: regwrite <= 1'b1;
               OP_ORI: begin
                  regwrite <= 1'b1;
                  alu_op   <= ALU_OR;
               end
               OP_BEQ: begin
                  alusrc <= 1'b1;
                  br_eq  <= 1'b1;
               end
               OP_BNE: begin
                  alusrc <= 1'b1;
                  br_ne  <= 1'b1;
               end
               default: ;  // STALL, JUMP and unknown opcodes issue as no-ops
            endcase
         end
      end
   end

   // Payload fields are only meaningful while ex_valid is high
   always_ff @(posedge clk) begin
      if (issue) begin
         dest    <= (opcode == OP_RTYPE) ? instr[15:11] : instr[20:16];
         imm_ext <= imm_next;
      end
   end

endmodule

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

   typedef logic [31:0] word_t;      // Register values, ALU results and memory data
   typedef logic [31:0] instr_t;     // opcode 31:26, rs 25:21, rt 20:16, rd 15:11, imm 15:0
   typedef logic [4:0]  reg_addr_t;  // Register number
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;

   // Major opcodes
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_JUMP  = 6'h02;
   localparam opcode_t OP_LDB   = 6'h10;
   localparam opcode_t OP_LDW   = 6'h11;
   localparam opcode_t OP_STB   = 6'h12;
   localparam opcode_t OP_STW   = 6'h13;
   localparam opcode_t OP_LI    = 6'h20;
   localparam opcode_t OP_ADDI  = 6'h21;
   localparam opcode_t OP_LUI   = 6'h22;
   localparam opcode_t OP_ORI   = 6'h23;
   localparam opcode_t OP_BEQ   = 6'h30;
   localparam opcode_t OP_BNE   = 6'h31;
   localparam opcode_t OP_STALL = 6'h3f;  // No-op

   // R-type function codes, MIPS numbering
   localparam funct_t FN_ADD = 6'h20;
   localparam funct_t FN_SUB = 6'h22;
   localparam funct_t FN_AND = 6'h24;
   localparam funct_t FN_OR  = 6'h25;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_PASS_B = 3'd4   // Forwards operand B, used by LI and LUI
   } alu_op_t;

endpackage

`default_nettype wire

/* src/exec_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipeline
   import core_pkg::*;
#(
   parameter int MEM_WORDS = 256
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      we,
   input  logic      stall,
   input  instr_t    instr,
   output logic      wb_valid,
   output reg_addr_t wb_addr,
   output word_t     wb_data,
   output logic      branch_taken
);

   // Issue stage to execute stage
   logic      issue;
   logic      ex_valid;
   logic      regwrite;
   logic      memtoreg;
   logic      memwrite;
   logic      memread;
   logic      byteword;
   logic      alusrc;
   logic      br_eq;
   logic      br_ne;
   alu_op_t   alu_op;
   reg_addr_t dest;
   word_t     imm_ext;
   word_t     rs_data;
   word_t     rt_data;

   // Execute stage to memory stage
   logic      m_regwrite;
   logic      m_memtoreg;
   logic      m_memwrite;
   logic      m_memread;
   logic      m_byteword;
   reg_addr_t m_dest;
   word_t     alu_result;
   word_t     store_data;

   control_unit i_control_unit (
      .clk      (clk),
      .reset    (reset),
      .we       (we),
      .stall    (stall),
      .instr    (instr),
      .issue    (issue),
      .ex_valid (ex_valid),
      .regwrite (regwrite),
      .memtoreg (memtoreg),
      .memwrite (memwrite),
      .memread  (memread),
      .byteword (byteword),
      .alusrc   (alusrc),
      .br_eq    (br_eq),
      .br_ne    (br_ne),
      .alu_op   (alu_op),
      .dest     (dest),
      .imm_ext  (imm_ext)
   );

   register_file i_register_file (
      .clk      (clk),
      .reset    (reset),
      .issue    (issue),
      .rs_addr  (instr[25:21]),
      .rt_addr  (instr[20:16]),
      .wb_valid (wb_valid),
      .wb_addr  (wb_addr),
      .wb_data  (wb_data),
      .rs_data  (rs_data),
      .rt_data  (rt_data)
   );

   execute_unit i_execute_unit (
      .clk          (clk),
      .reset        (reset),
      .ex_valid     (ex_valid),
      .regwrite     (regwrite),
      .memtoreg     (memtoreg),
      .memwrite     (memwrite),
      .memread      (memread),
      .byteword     (byteword),
      .alusrc       (alusrc),
      .br_eq        (br_eq),
      .br_ne        (br_ne),
      .alu_op       (alu_op),
      .dest         (dest),
      .imm_ext      (imm_ext),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .m_regwrite   (m_regwrite),
      .m_memtoreg   (m_memtoreg),
      .m_memwrite   (m_memwrite),
      .m_memread    (m_memread),
      .m_byteword   (m_byteword),
      .m_dest       (m_dest),
      .alu_result   (alu_result),
      .store_data   (store_data),
      .branch_taken (branch_taken)
   );

   memory_stage #(
      .MEM_WORDS (MEM_WORDS)
   ) i_memory_stage (
      .clk        (clk),
      .reset      (reset),
      .m_regwrite (m_regwrite),
      .m_memtoreg (m_memtoreg),
      .m_memwrite (m_memwrite),
      .m_memread  (m_memread),
      .m_byteword (m_byteword),
      .m_dest     (m_dest),
      .alu_result (alu_result),
      .store_data (store_data),
      .wb_valid   (wb_valid),
      .wb_addr    (wb_addr),
      .wb_data    (wb_data)
   );

endmodule

`default_nettype wire

/* src/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit
   import core_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      ex_valid,
   input  logic      regwrite,
   input  logic      memtoreg,
   input  logic      memwrite,
   input  logic      memread,
   input  logic      byteword,
   input  logic      alusrc,
   input  logic      br_eq,
   input  logic      br_ne,
   input  alu_op_t   alu_op,
   input  reg_addr_t dest,
   input  word_t     imm_ext,
   input  word_t     rs_data,
   input  word_t     rt_data,
   output logic      m_regwrite,
   output logic      m_memtoreg,
   output logic      m_memwrite,
   output logic      m_memread,
   output logic      m_byteword,
   output reg_addr_t m_dest,
   output word_t     alu_result,
   output word_t     store_data,
   output logic      branch_taken
);

   word_t operand_b;
   word_t result;
   logic  equal;

   assign operand_b = alusrc ? rt_data : imm_ext;
   assign equal     = (rs_data == rt_data);

   always_comb begin
      case (alu_op)
         ALU_SUB:    result = rs_data - operand_b;
         ALU_AND:    result = rs_data & operand_b;
         ALU_OR:     result = rs_data | operand_b;
         ALU_PASS_B: result = operand_b;
         default:    result = rs_data + operand_b;  // Also the load/store address
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         m_regwrite   <= 1'b0;
         m_memtoreg   <= 1'b0;
         m_memwrite   <= 1'b0;
         m_memread    <= 1'b0;
         m_byteword   <= 1'b0;
         branch_taken <= 1'b0;
      end else begin
         m_regwrite   <= ex_valid & regwrite;
         m_memtoreg   <= ex_valid & memtoreg;
         m_memwrite   <= ex_valid & memwrite;
         m_memread    <= ex_valid & memread;
         m_byteword   <= ex_valid & byteword;
         branch_taken <= ex_valid & ((br_eq & equal) | (br_ne & ~equal));  // One-cycle pulse
      end
   end

   always_ff @(posedge clk) begin
      m_dest     <= ex_valid ? dest : '0;
      alu_result <= ex_valid ? result : '0;
      store_data <= ex_valid ? rt_data : '0;
   end

endmodule

`default_nettype wire

/* src/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage
   import core_pkg::*;
#(
   parameter int MEM_WORDS = 256
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      m_regwrite,
   input  logic      m_memtoreg,
   input  logic      m_memwrite,
   input  logic      m_memread,
   input  logic      m_byteword,
   input  reg_addr_t m_dest,
   input  word_t     alu_result,
   input  word_t     store_data,
   output logic      wb_valid,
   output reg_addr_t wb_addr,
   output word_t     wb_data
);

   localparam int ADDR_W = $clog2(MEM_WORDS);

   word_t             mem [MEM_WORDS];
   logic [ADDR_W-1:0] word_idx;
   logic [1:0]        lane;
   word_t             rd_word;
   logic [7:0]        rd_byte;
   word_t             load_data;

   // Address wraps modulo the memory size
   assign word_idx = alu_result[ADDR_W+1:2];
   assign lane     = alu_result[1:0];

   always_ff @(posedge clk) begin
      if (m_memwrite) begin
         if (m_byteword) begin
            mem[word_idx] <= store_data;
         end else begin
            mem[word_idx][lane*8 +: 8] <= store_data[7:0];  // Little-endian byte lane
         end
      end
   end

   assign rd_word   = m_memread ? mem[word_idx] : '0;
   assign rd_byte   = rd_word[lane*8 +: 8];
   assign load_data = m_byteword ? rd_word : {24'b0, rd_byte};  // LDB zero-extends

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= m_regwrite;  // Pulses for register 0 as well
      end
   end

   always_ff @(posedge clk) begin
      wb_addr <= m_dest;
      wb_data <= m_memtoreg ? load_data : alu_result;
   end

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
   import core_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      issue,     // Read enable for both ports
   input  reg_addr_t rs_addr,
   input  reg_addr_t rt_addr,
   input  logic      wb_valid,
   input  reg_addr_t wb_addr,
   input  word_t     wb_data,
   output word_t     rs_data,
   output word_t     rt_data
);

   word_t regs [1:31];  // Register 0 is hardwired to zero

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_valid && (wb_addr != 5'd0)) begin
         regs[wb_addr] <= wb_data;
      end
   end

   // Reads see the array before this edge's write-back, so no bypass here
   always_ff @(posedge clk) begin
      if (issue) begin
         rs_data <= (rs_addr == 5'd0) ? '0 : regs[rs_addr];
         rt_data <= (rt_addr == 5'd0) ? '0 : regs[rt_addr];
      end
   end

endmodule

`default_nettype wire

/* testbench/exec_pipeline_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipeline_checker (
   input logic clk,
   input logic reset,
   input logic ex_valid,
   input logic regwrite,
   input logic memtoreg,
   input logic memwrite,
   input logic memread,
   input logic br_eq,
   input logic br_ne,
   input logic m_regwrite,
   input logic m_memwrite,
   input logic m_memread,
   input logic branch_taken
);

   int error_count = 0;  // Read by the testbench when the run ends

   a_store_no_wb: assert property (@(posedge clk) disable iff (reset) !(memwrite && regwrite))
      else begin
         error_count++;
         $error("memwrite and regwrite are set in the same cycle");
      end

   a_load_to_reg: assert property (@(posedge clk) disable iff (reset) memread |-> memtoreg)
      else begin
         error_count++;
         $error("memread is set without memtoreg");
      end

   // A taken branch needs a valid branch instruction in execute one cycle earlier
   a_branch_cause: assert property (@(posedge clk) disable iff (reset)
         branch_taken |-> $past(ex_valid && (br_eq || br_ne)))
      else begin
         error_count++;
         $error("branch_taken without a branch in execute");
      end

   a_reset_idle: assert property (@(posedge clk) reset |=> !ex_valid && !regwrite && !memtoreg
         && !memwrite && !memread && !m_regwrite && !m_memwrite && !m_memread && !branch_taken)
      else begin
         error_count++;
         $error("Control outputs active after a reset edge");
      end

endmodule

// Control unit outputs are observed where they enter the execute stage
bind execute_unit exec_pipeline_checker i_checker (
   .clk          (clk),
   .reset        (reset),
   .ex_valid     (ex_valid),
   .regwrite     (regwrite),
   .memtoreg     (memtoreg),
   .memwrite     (memwrite),
   .memread      (memread),
   .br_eq        (br_eq),
   .br_ne        (br_ne),
   .m_regwrite   (m_regwrite),
   .m_memwrite   (m_memwrite),
   .m_memread    (m_memread),
   .branch_taken (branch_taken)
);

`default_nettype wire

/* testbench/exec_pipeline_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipeline_tb
   import core_pkg::*;
();

   localparam int MEM_WORDS = 256;
   localparam int MEM_BYTES = 4 * MEM_WORDS;

   logic      clk;
   logic      reset;
   logic      we;
   logic      stall;
   instr_t    instr;
   logic      wb_valid;
   reg_addr_t wb_addr;
   word_t     wb_data;
   logic      branch_taken;

   word_t      model_regs [32];
   logic [7:0] model_mem [MEM_BYTES];  // Little-endian byte view of the data memory
   word_t      lcg_state = 32'd24898;
   int         cycle = 0;
   int         issued = 0;
   logic       exp_br;

   int         wb_due_q [$];  // Cycle in which each write-back shows at the ports
   reg_addr_t  wb_addr_q [$];
   word_t      wb_data_q [$];
   logic       exp_branch [int];

   exec_pipeline #(
      .MEM_WORDS (MEM_WORDS)
   ) i_dut (
      .clk          (clk),
      .reset        (reset),
      .we           (we),
      .stall        (stall),
      .instr        (instr),
      .wb_valid     (wb_valid),
      .wb_addr      (wb_addr),
      .wb_data      (wb_data),
      .branch_taken (branch_taken)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   function automatic word_t next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [15:0] rand16();
      word_t r;
      r = next_rand();
      return r[23:8];  // Low LCG bits repeat too quickly
   endfunction

   function automatic instr_t enc_i(opcode_t op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic instr_t enc_r(funct_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
      return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic opcode_t noop_code(logic [1:0] sel);
      case (sel)
         2'd0:    return OP_STALL;
         2'd1:    return OP_JUMP;
         2'd2:    return 6'h0a;  // Unassigned opcodes
         default: return 6'h3b;
      endcase
   endfunction

   // Architectural model of one instruction, executed in program order
   function automatic void ref_execute(input instr_t i, output logic wv, output reg_addr_t wa,
                                       output word_t wd, output logic br);
      word_t a;
      word_t b;
      word_t sx;
      word_t addr;
      int    idx;
      int    base;
      a    = model_regs[i[25:21]];
      b    = model_regs[i[20:16]];
      sx   = {{16{i[15]}}, i[15:0]};
      addr = a + sx;
      idx  = int'(addr % MEM_BYTES);  // Addresses wrap at the memory size
      base = idx - idx % 4;
      wv   = 1'b0;
      wa   = i[20:16];
      wd   = '0;
      br   = 1'b0;
      case (opcode_t'(i[31:26]))
         OP_RTYPE: begin
            wv = 1'b1;
            wa = i[15:11];
            case (funct_t'(i[5:0]))
               FN_SUB:  wd = a - b;
               FN_AND:  wd = a & b;
               FN_OR:   wd = a | b;
               default: wd = a + b;
            endcase
         end
         OP_LI: begin
            wv = 1'b1;
            wd = sx;
         end
         OP_ADDI: begin
            wv = 1'b1;
            wd = a + sx;
         end
         OP_ORI: begin
            wv = 1'b1;
            wd = a | {16'h0, i[15:0]};
         end
         OP_LUI: begin
            wv = 1'b1;
            wd = {i[15:0], 16'h0};
         end
         OP_LDB: begin
            wv = 1'b1;
            wd = {24'h0, model_mem[idx]};
         end
         OP_LDW: begin
            wv = 1'b1;
            wd = {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
         end
         OP_STB: model_mem[idx] = b[7:0];
         OP_STW: begin
            for (int k = 0; k < 4; k++) begin
               model_mem[base+k] = b[8*k +: 8];
            end
         end
         OP_BEQ: br = (a == b);
         OP_BNE: br = (a != b);
         default: ;
      endcase
      if (wv && wa != 5'd0) begin
         model_regs[wa] = wd;  // Register 0 stays zero
      end
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         fail_run($sformatf("** Error at %0d ns: %s expected 0x%08h, actual 0x%08h",
                            $time, name, exp, act));
      end
   endtask

   task automatic check_wb_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
      if (act !== exp) begin
         fail_run($sformatf("** Error at %0d ns: %s expected %0d, actual %0d",
                            $time, name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_run($sformatf("** Error at %0d ns: %s expected %b, actual %b",
                            $time, name, exp, act));
      end
   endtask

   // Outputs are registered, so the falling edge sees them settled
   always @(negedge clk) begin
      if (!reset) begin
         exp_br = exp_branch.exists(cycle) ? exp_branch[cycle] : 1'b0;
         check_bit("branch_taken", exp_br, branch_taken);
         if (exp_branch.exists(cycle)) begin
            exp_branch.delete(cycle);
         end
         if (wb_due_q.size() != 0 && wb_due_q[0] == cycle) begin
            if (wb_valid !== 1'b1) begin
               fail_run($sformatf("Write-back to r%0d did not arrive at %0d ns",
                                  wb_addr_q[0], $time));
            end
            check_wb_addr("wb_addr", wb_addr_q[0], wb_addr);
            check_word("wb_data", wb_data_q[0], wb_data);
            void'(wb_due_q.pop_front());
            void'(wb_addr_q.pop_front());
            void'(wb_data_q.pop_front());
         end else begin
            check_bit("wb_valid", 1'b0, wb_valid);
         end
      end
   end

   initial begin
      forever begin
         @(posedge clk);
         if (cycle > 40 * issued + 200) begin
            fail_run("Watchdog expired before the tests completed");
         end
      end
   end

   task automatic issue_instr(input instr_t i);
      logic      wv;
      reg_addr_t wa;
      word_t     wd;
      logic      br;
      @(negedge clk);
      we    = 1'b1;
      stall = 1'b0;
      instr = i;
      ref_execute(i, wv, wa, wd, br);
      if (wv) begin
         wb_due_q.push_back(cycle + 3);  // Accepted at the next edge, result two edges later
         wb_addr_q.push_back(wa);
         wb_data_q.push_back(wd);
      end
      if (br) begin
         exp_branch[cycle + 2] = 1'b1;
      end
      issued++;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         we    = 1'b0;
         stall = 1'b0;
         instr = enc_i(OP_LI, 5'd9, 5'd0, rand16());
      end
   endtask

   task automatic stalled_cycles(input int n);
      instr_t held;
      held = enc_i(OP_LI, 5'd9, 5'd0, rand16());
      repeat (n) begin
         @(negedge clk);
         we    = 1'b1;
         stall = 1'b1;
         instr = held;
      end
   endtask

   task automatic settle();
      idle_cycles(4);  // Lets every pending result reach the register file
   endtask

   task automatic run_immediates();
      for (int round = 0; round < 3; round++) begin
         for (int k = 0; k < 4; k++) begin
            issue_instr(enc_i(OP_LI, reg_addr_t'(1 + k), 5'd0, rand16()));
         end
         settle();
         issue_instr(enc_i(OP_ADDI, 5'd5, 5'd1, rand16()));
         issue_instr(enc_i(OP_ORI, 5'd6, 5'd2, rand16()));
         issue_instr(enc_i(OP_LUI, 5'd7, 5'd3, rand16()));
         issue_instr(enc_i(OP_ADDI, 5'd8, 5'd4, rand16()));
         settle();
      end
   endtask

   task automatic run_rtype();
      for (int round = 0; round < 2; round++) begin
         for (int k = 0; k < 4; k++) begin
            issue_instr(enc_i(OP_LUI, reg_addr_t'(10 + k), 5'd0, rand16()));
         end
         settle();
         for (int k = 0; k < 4; k++) begin
            issue_instr(enc_i(OP_ORI, reg_addr_t'(10 + k), reg_addr_t'(10 + k), rand16()));
         end
         settle();
         issue_instr(enc_r(FN_ADD, 5'd14, 5'd10, 5'd11));
         issue_instr(enc_r(FN_SUB, 5'd15, 5'd10, 5'd11));
         issue_instr(enc_r(FN_AND, 5'd16, 5'd12, 5'd13));
         issue_instr(enc_r(FN_OR, 5'd17, 5'd12, 5'd13));
         issue_instr(enc_r(FN_ADD, 5'd0, 5'd10, 5'd12));
         settle();
         issue_instr(enc_r(FN_ADD, 5'd18, 5'd0, 5'd13));  // r0 must still read zero
         issue_instr(enc_r(FN_SUB, 5'd19, 5'd14, 5'd0));
         settle();
      end
   endtask

   task automatic run_memory();
      logic [15:0] base;
      for (int round = 0; round < 3; round++) begin
         base = rand16() & 16'hfff0;
         issue_instr(enc_i(OP_LI, 5'd20, 5'd0, base));
         issue_instr(enc_i(OP_LI, 5'd10, 5'd0, rand16()));
         settle();
         issue_instr(enc_i(OP_STW, 5'd10, 5'd20, 16'd0));
         issue_instr(enc_i(OP_STB, 5'd15, 5'd20, 16'd2));  // Merges into the word just stored
         for (int k = 0; k < 4; k++) begin
            issue_instr(enc_i(OP_STB, reg_addr_t'(11 + k), 5'd20, 16'(4 + k)));
         end
         issue_instr(enc_i(OP_LDW, 5'd21, 5'd20, 16'd0));
         issue_instr(enc_i(OP_LDW, 5'd22, 5'd20, 16'd4));
         for (int k = 0; k < 4; k++) begin
            issue_instr(enc_i(OP_LDB, reg_addr_t'(23 + k), 5'd20, 16'(4 + k)));
         end
         settle();
      end
   endtask

   task automatic run_branches();
      issue_instr(enc_i(OP_BEQ, 5'd10, 5'd10, rand16()));
      issue_instr(enc_i(OP_BEQ, 5'd11, 5'd10, rand16()));
      issue_instr(enc_i(OP_BNE, 5'd11, 5'd10, rand16()));
      issue_instr(enc_i(OP_BNE, 5'd12, 5'd12, rand16()));
      issue_instr(enc_i(OP_BEQ, 5'd0, 5'd0, rand16()));
      issue_instr(enc_i(OP_BNE, 5'd14, 5'd0, rand16()));
      settle();
   endtask

   task automatic run_mixed_stream();
      word_t     r;
      reg_addr_t dst;
      for (int n = 0; n < 32; n++) begin
         r   = next_rand();
         dst = reg_addr_t'(24 + r[2:0]);
         case (r[29:27])
            3'd0, 3'd1: issue_instr(enc_i(OP_LI, dst, 5'd0, r[23:8]));
            3'd2: issue_instr(enc_i(OP_ADDI, dst, 5'd0, r[23:8]));
            3'd3: issue_instr(enc_i(OP_ORI, dst, 5'd0, r[23:8]));
            3'd4: issue_instr(enc_i(noop_code(r[4:3]), dst, 5'd0, r[23:8]));
            3'd5: idle_cycles(1 + r[5]);
            3'd6: stalled_cycles(1 + r[6]);
            default: issue_instr(enc_i(OP_LUI, dst, 5'd0, r[23:8]));
         endcase
      end
      settle();
   endtask

   initial begin
      reset = 1'b1;
      we    = 1'b0;
      stall = 1'b0;
      instr = '0;
      for (int k = 0; k < 32; k++) begin
         model_regs[k] = '0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      run_immediates();
      run_rtype();
      run_memory();
      run_branches();
      run_mixed_stream();
      idle_cycles(4);  // A stray write-back would show up here
      if (i_dut.i_execute_unit.i_checker.error_count != 0) begin
         fail_run("A pipeline control assertion failed during the run");
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire
